//--- design/i3c_bus_pkg.sv
// Bus-level widths, byte and address types shared by the CCC handler and its testbench
`default_nettype none

package i3c_bus_pkg;

  // Basic bus widths
  localparam int BYTE_W = 8;
  localparam int ADDR_W = 7;

  // One byte as seen on SDA, MSB first
  typedef logic [BYTE_W-1:0] bus_byte_t;

  // Target address without the R/W bit
  typedef logic [ADDR_W-1:0] addr7_t;

  // Broadcast address 7'h7E with write direction
  // Seen after Repeated Start, it closes a direct CCC
  localparam bus_byte_t RSVD_ADDR = {7'h7E, 1'b0};

endpackage : i3c_bus_pkg

`default_nettype wire

//--- design/i3c_ccc_pkg.sv
// CCC code values, GET response lengths and sequencer states, imported by the CCC handler units
`default_nettype none

package i3c_ccc_pkg;

  localparam int CCC_W = 8;

  // Bit 7 set marks a direct command
  typedef logic [CCC_W-1:0] ccc_code_t;

  // Broadcast codes
  localparam ccc_code_t CCC_BCAST_RSTDAA  = 8'h06;
  localparam ccc_code_t CCC_BCAST_SETAASA = 8'h29;

  // Direct codes
  localparam ccc_code_t CCC_DIRECT_SETDASA   = 8'h87;
  localparam ccc_code_t CCC_DIRECT_GETMWL    = 8'h8B;
  localparam ccc_code_t CCC_DIRECT_GETMRL    = 8'h8C;
  localparam ccc_code_t CCC_DIRECT_GETPID    = 8'h8D;
  localparam ccc_code_t CCC_DIRECT_GETBCR    = 8'h8E;
  localparam ccc_code_t CCC_DIRECT_GETDCR    = 8'h8F;
  localparam ccc_code_t CCC_DIRECT_GETSTATUS = 8'h90;

  // Longest GET response, GETPID
  localparam int MAX_GET_LEN = 6;
  localparam int IDX_W       = $clog2(MAX_GET_LEN + 1);
  localparam int GET_RESP_W  = MAX_GET_LEN * 8;

  // Countdown of bytes still to send
  typedef logic [IDX_W-1:0] byte_idx_t;

  // Response byte counts per GET
  localparam byte_idx_t GET_LEN_BCR    = 3'd1;
  localparam byte_idx_t GET_LEN_DCR    = 3'd1;
  localparam byte_idx_t GET_LEN_STATUS = 3'd2;
  localparam byte_idx_t GET_LEN_MWL    = 3'd2;
  localparam byte_idx_t GET_LEN_MRL    = 3'd3;
  localparam byte_idx_t GET_LEN_PID    = 3'd6;

  // Frame walk after the command code
  typedef enum logic [3:0] {
    Idle,
    WaitCCC,
    RxTbit,
    WaitRstart,
    RxDirectAddr,
    TxDirectAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    HandleBroadcast,
    DoneCCC
  } ccc_state_e;

endpackage : i3c_ccc_pkg

`default_nettype wire

//--- design/ccc_sequencer.sv
// Walks a CCC frame after the primary FSM hands over and drives bit and byte requests to the bus
`timescale 1ns/10ps
`default_nettype none

module ccc_sequencer
  import i3c_bus_pkg::*;
  import i3c_ccc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ccc_code_t ccc_i,
  input  logic      ccc_valid_i,
  input  logic      start_det_i,
  input  logic      rstart_det_i,
  input  logic      stop_det_i,
  input  logic      rx_done_i,
  input  bus_byte_t rx_data_i,
  input  logic      tx_done_i,
  input  addr7_t    sta_addr_i,
  input  addr7_t    dyn_addr_i,
  input  logic      sta_addr_valid_i,
  input  logic      dyn_addr_valid_i,
  input  bus_byte_t tx_byte_i,
  input  logic      tx_last_i,
  output logic      rx_req_bit_o,
  output logic      rx_req_byte_o,
  output logic      tx_req_bit_o,
  output logic      tx_req_byte_o,
  output bus_byte_t tx_value_o,
  output logic      done_fsm_o,
  output ccc_code_t cmd_code_o,
  output logic      tx_load_o,
  output logic      tx_advance_o,
  output logic      bcast_strobe_o,
  output logic      data_strobe_o,
  output bus_byte_t data_byte_o
);

  ccc_state_e state_q, state_d;
  addr7_t     addr_q;
  logic       rnw_q;
  logic       is_rsvd_addr;
  logic       is_our_addr;

  // Command code held for the whole frame
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_code_o <= '0;
    end else if (ccc_valid_i && state_q == WaitCCC) begin
      cmd_code_o <= ccc_i;
    end
  end

  // Address byte after Repeated Start
  always_ff @(posedge clk_i) begin
    if (state_q == RxDirectAddr && rx_done_i) begin
      addr_q <= rx_data_i[7:1];
      rnw_q  <= rx_data_i[0];
    end
  end

  // Write data, handed on once its T-bit is in
  always_ff @(posedge clk_i) begin
    if (state_q == RxData && rx_done_i) begin
      data_byte_o <= rx_data_i;
    end
  end

  assign is_rsvd_addr = {addr_q, rnw_q} == RSVD_ADDR;

  // Dynamic address wins, static one only as fallback
  always_comb begin
    if (dyn_addr_valid_i) begin
      is_our_addr = addr_q == dyn_addr_i;
    end else if (sta_addr_valid_i) begin
      is_our_addr = addr_q == sta_addr_i;
    end else begin
      is_our_addr = 1'b0;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: state_d = WaitCCC;
      WaitCCC: begin
        if (ccc_valid_i) state_d = RxTbit;
      end
      RxTbit: begin
        if (rx_done_i) state_d = cmd_code_o[7] ? WaitRstart : HandleBroadcast;
      end
      // Defining bytes are not taken, just wait for Sr
      WaitRstart: begin
        if (rstart_det_i) state_d = RxDirectAddr;
      end
      RxDirectAddr: begin
        if (rx_done_i) state_d = TxDirectAddrAck;
      end
      TxDirectAddrAck: begin
        if (tx_done_i) begin
          if (is_rsvd_addr) state_d = DoneCCC;
          else if (is_our_addr && rnw_q) state_d = TxData;
          else if (is_our_addr) state_d = RxData;
          else state_d = RxDirectAddr;
        end
      end
      RxData: begin
        if (start_det_i) state_d = RxDirectAddr;
        else if (rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit: begin
        if (rx_done_i) state_d = RxData;
      end
      TxData: begin
        if (start_det_i) state_d = RxDirectAddr;
        else if (tx_done_i) state_d = TxDataTbit;
      end
      // Last byte sent, next target may follow
      TxDataTbit: begin
        if (tx_done_i) state_d = tx_last_i ? RxDirectAddr : TxData;
      end
      HandleBroadcast: state_d = DoneCCC;
      DoneCCC: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  // STOP ends the frame from anywhere
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (stop_det_i && state_q != DoneCCC) begin
      state_q <= DoneCCC;
    end else begin
      state_q <= state_d;
    end
  end

  // Request levels follow the state
  assign rx_req_bit_o  = state_q inside {RxTbit, RxDataTbit};
  assign rx_req_byte_o = state_q inside {RxDirectAddr, RxData};
  assign tx_req_bit_o  = state_q inside {TxDirectAddrAck, TxDataTbit};
  assign tx_req_byte_o = state_q == TxData;

  // ACK is 0, T-bit high while more bytes remain
  always_comb begin
    case (state_q)
      TxData:     tx_value_o = tx_byte_i;
      TxDataTbit: tx_value_o = {7'h00, ~tx_last_i};
      default:    tx_value_o = '0;
    endcase
  end

  assign done_fsm_o     = state_q == DoneCCC;
  assign bcast_strobe_o = state_q == HandleBroadcast;
  assign data_strobe_o  = state_q == RxDataTbit && rx_done_i;
  assign tx_advance_o   = state_q == TxData && tx_done_i;
  assign tx_load_o      = state_q == TxDirectAddrAck && tx_done_i && is_our_addr && rnw_q;

  // Transceiver takes one kind of request at a time
  a_req_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((rx_req_bit_o || tx_req_bit_o) && (rx_req_byte_o || tx_req_byte_o)));

  // Handback to the primary FSM is a single pulse
  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_o |=> !done_fsm_o);

endmodule : ccc_sequencer

`default_nettype wire

//--- design/get_response_mux.sv
// Counts down the bytes of a direct GET response and selects the byte to send next
`timescale 1ns/10ps
`default_nettype none

module get_response_mux
  import i3c_bus_pkg::*;
  import i3c_ccc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ccc_code_t             cmd_code_i,
  input  logic                  tx_load_i,
  input  logic                  tx_advance_i,
  input  bus_byte_t             get_bcr_i,
  input  bus_byte_t             get_dcr_i,
  input  logic [2*BYTE_W-1:0]   get_status_i,
  input  logic [2*BYTE_W-1:0]   get_mwl_i,
  input  logic [2*BYTE_W-1:0]   get_mrl_i,
  input  logic [GET_RESP_W-1:0] get_pid_i,
  output bus_byte_t             tx_byte_o,
  output logic                  tx_last_o
);

  byte_idx_t             cnt_q;
  byte_idx_t             len;
  logic [GET_RESP_W-1:0] resp;

  // Response right aligned, byte at count N sits at [8N-1 -: 8]
  always_comb begin
    case (cmd_code_i)
      CCC_DIRECT_GETBCR: begin
        len  = GET_LEN_BCR;
        resp = {40'h0, get_bcr_i};
      end
      CCC_DIRECT_GETDCR: begin
        len  = GET_LEN_DCR;
        resp = {40'h0, get_dcr_i};
      end
      // Format 1 only
      CCC_DIRECT_GETSTATUS: begin
        len  = GET_LEN_STATUS;
        resp = {32'h0, get_status_i};
      end
      CCC_DIRECT_GETMWL: begin
        len  = GET_LEN_MWL;
        resp = {32'h0, get_mwl_i};
      end
      // Third byte is max IBI payload, all ones
      CCC_DIRECT_GETMRL: begin
        len  = GET_LEN_MRL;
        resp = {24'h0, get_mrl_i, 8'hFF};
      end
      CCC_DIRECT_GETPID: begin
        len  = GET_LEN_PID;
        resp = get_pid_i;
      end
      default: begin
        len  = '0;
        resp = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (tx_load_i) begin
      cnt_q <= len;
    end else if (tx_advance_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // MSB of what is left goes first
  always_comb begin
    case (cnt_q)
      3'd1:    tx_byte_o = resp[7:0];
      3'd2:    tx_byte_o = resp[15:8];
      3'd3:    tx_byte_o = resp[23:16];
      3'd4:    tx_byte_o = resp[31:24];
      3'd5:    tx_byte_o = resp[39:32];
      3'd6:    tx_byte_o = resp[47:40];
      default: tx_byte_o = '0;
    endcase
  end

  assign tx_last_o = cnt_q == '0;

  // Sequencer must stop sending once the count is spent
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_advance_i |-> cnt_q != '0);

endmodule : get_response_mux

`default_nettype wire

//--- design/set_action_unit.sv
// Turns completed broadcast and SETDASA frames into RSTDAA and dynamic-address pulses for the CSRs
`timescale 1ns/10ps
`default_nettype none

module set_action_unit
  import i3c_bus_pkg::*;
  import i3c_ccc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ccc_code_t cmd_code_i,
  input  logic      bcast_strobe_i,
  input  logic      data_strobe_i,
  input  bus_byte_t data_byte_i,
  input  addr7_t    sta_addr_i,
  output logic      rstdaa_o,
  output bus_byte_t set_dasa_o,
  output logic      set_dasa_valid_o
);

  logic      aasa_valid_q;
  bus_byte_t aasa_addr_q;
  logic      dasa_valid_q;
  bus_byte_t dasa_addr_q;

  // Strobes last one cycle, so do the pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rstdaa_o     <= 1'b0;
      aasa_valid_q <= 1'b0;
      dasa_valid_q <= 1'b0;
    end else begin
      rstdaa_o     <= bcast_strobe_i && cmd_code_i == CCC_BCAST_RSTDAA;
      aasa_valid_q <= bcast_strobe_i && cmd_code_i == CCC_BCAST_SETAASA;
      dasa_valid_q <= data_strobe_i && cmd_code_i == CCC_DIRECT_SETDASA;
    end
  end

  // SETAASA promotes the static address, laid out like a SETDASA byte
  always_ff @(posedge clk_i) begin
    if (bcast_strobe_i && cmd_code_i == CCC_BCAST_SETAASA) begin
      aasa_addr_q <= {sta_addr_i, 1'b0};
    end
  end

  // SETDASA byte carries the new address in [7:1]
  always_ff @(posedge clk_i) begin
    if (data_strobe_i && cmd_code_i == CCC_DIRECT_SETDASA) begin
      dasa_addr_q <= data_byte_i;
    end
  end

  // Both feed one CSR write port
  assign set_dasa_valid_o = aasa_valid_q || dasa_valid_q;
  assign set_dasa_o       = aasa_valid_q ? aasa_addr_q : dasa_addr_q;

  // One frame never both resets and assigns the address
  a_rst_set_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rstdaa_o && set_dasa_valid_o));

endmodule : set_action_unit

`default_nettype wire

//--- design/ccc_handler_top.sv
// Top level of the I3C target CCC handler, joining sequencer, GET response mux and SET actions
`timescale 1ns/10ps
`default_nettype none

module ccc_handler_top
  import i3c_bus_pkg::*;
  import i3c_ccc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // From the primary FSM
  input  ccc_code_t             ccc_i,
  input  logic                  ccc_valid_i,
  output logic                  done_fsm_o,
  // Bus monitor
  input  logic                  start_det_i,
  input  logic                  rstart_det_i,
  input  logic                  stop_det_i,
  // Transceiver
  input  logic                  rx_done_i,
  input  bus_byte_t             rx_data_i,
  input  logic                  tx_done_i,
  output logic                  rx_req_bit_o,
  output logic                  rx_req_byte_o,
  output logic                  tx_req_bit_o,
  output logic                  tx_req_byte_o,
  output bus_byte_t             tx_value_o,
  // CSR side
  input  addr7_t                sta_addr_i,
  input  logic                  sta_addr_valid_i,
  input  addr7_t                dyn_addr_i,
  input  logic                  dyn_addr_valid_i,
  input  bus_byte_t             get_bcr_i,
  input  bus_byte_t             get_dcr_i,
  input  logic [2*BYTE_W-1:0]   get_status_i,
  input  logic [2*BYTE_W-1:0]   get_mwl_i,
  input  logic [2*BYTE_W-1:0]   get_mrl_i,
  input  logic [GET_RESP_W-1:0] get_pid_i,
  output logic                  rstdaa_o,
  output bus_byte_t             set_dasa_o,
  output logic                  set_dasa_valid_o
);

  ccc_code_t cmd_code;
  logic      tx_load;
  logic      tx_advance;
  bus_byte_t tx_byte;
  logic      tx_last;
  logic      bcast_strobe;
  logic      data_strobe;
  bus_byte_t data_byte;

  ccc_sequencer u_seq (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ccc_i            (ccc_i),
    .ccc_valid_i      (ccc_valid_i),
    .start_det_i      (start_det_i),
    .rstart_det_i     (rstart_det_i),
    .stop_det_i       (stop_det_i),
    .rx_done_i        (rx_done_i),
    .rx_data_i        (rx_data_i),
    .tx_done_i        (tx_done_i),
    .sta_addr_i       (sta_addr_i),
    .dyn_addr_i       (dyn_addr_i),
    .sta_addr_valid_i (sta_addr_valid_i),
    .dyn_addr_valid_i (dyn_addr_valid_i),
    .tx_byte_i        (tx_byte),
    .tx_last_i        (tx_last),
    .rx_req_bit_o     (rx_req_bit_o),
    .rx_req_byte_o    (rx_req_byte_o),
    .tx_req_bit_o     (tx_req_bit_o),
    .tx_req_byte_o    (tx_req_byte_o),
    .tx_value_o       (tx_value_o),
    .done_fsm_o       (done_fsm_o),
    .cmd_code_o       (cmd_code),
    .tx_load_o        (tx_load),
    .tx_advance_o     (tx_advance),
    .bcast_strobe_o   (bcast_strobe),
    .data_strobe_o    (data_strobe),
    .data_byte_o      (data_byte)
  );

  get_response_mux u_get (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_code_i   (cmd_code),
    .tx_load_i    (tx_load),
    .tx_advance_i (tx_advance),
    .get_bcr_i    (get_bcr_i),
    .get_dcr_i    (get_dcr_i),
    .get_status_i (get_status_i),
    .get_mwl_i    (get_mwl_i),
    .get_mrl_i    (get_mrl_i),
    .get_pid_i    (get_pid_i),
    .tx_byte_o    (tx_byte),
    .tx_last_o    (tx_last)
  );

  set_action_unit u_set (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_code_i       (cmd_code),
    .bcast_strobe_i   (bcast_strobe),
    .data_strobe_i    (data_strobe),
    .data_byte_i      (data_byte),
    .sta_addr_i       (sta_addr_i),
    .rstdaa_o         (rstdaa_o),
    .set_dasa_o       (set_dasa_o),
    .set_dasa_valid_o (set_dasa_valid_o)
  );

endmodule : ccc_handler_top

`default_nettype wire

//--- tb/ccc_bus_model.svh
// Transceiver and bus monitor emulation plus compare tasks, included in the CCC handler testbench
`ifndef CCC_BUS_MODEL_SVH
`define CCC_BUS_MODEL_SVH

// DUT level a wait loop watches
typedef enum int {
  REQ_RX_BIT,
  REQ_RX_BYTE,
  REQ_TX_BIT,
  REQ_TX_BYTE,
  DONE_PULSE
} wait_kind_e;

function automatic logic level_of(input wait_kind_e kind);
  case (kind)
    REQ_RX_BIT:  return rx_req_bit_o;
    REQ_RX_BYTE: return rx_req_byte_o;
    REQ_TX_BIT:  return tx_req_bit_o;
    REQ_TX_BYTE: return tx_req_byte_o;
    default:     return done_fsm_o;
  endcase
endfunction

// Inputs change 1 ns after the rising edge
task automatic next_cycle();
  @(posedge clk_i);
  #1;
endtask

task automatic wait_for(input wait_kind_e kind, output logic seen);
  int n;
  n = 0;
  while (!level_of(kind) && n < TIMEOUT_CYC) begin
    next_cycle();
    n++;
  end
  seen = level_of(kind);
  if (!seen) begin
    $display("Timeout at %0t: %s never seen within %0d cycles", $time, kind.name(),
             TIMEOUT_CYC);
    timeout_cnt++;
  end
endtask

// RX side, one done pulse per request
task automatic send_bit(input logic value);
  logic seen;
  wait_for(REQ_RX_BIT, seen);
  if (seen) begin
    rx_data_i = {7'h00, value};
    rx_done_i = 1'b1;
    next_cycle();
    rx_done_i = 1'b0;
  end
endtask

task automatic send_byte(input bus_byte_t value);
  logic seen;
  wait_for(REQ_RX_BYTE, seen);
  if (seen) begin
    rx_data_i = value;
    rx_done_i = 1'b1;
    next_cycle();
    rx_done_i = 1'b0;
  end
endtask

// TX side, value sampled while the request is held
task automatic take_tx_bit(output logic value);
  logic seen;
  wait_for(REQ_TX_BIT, seen);
  value = tx_value_o[0];
  if (seen) begin
    tx_done_i = 1'b1;
    next_cycle();
    tx_done_i = 1'b0;
  end
endtask

task automatic take_tx_byte(output bus_byte_t value);
  logic seen;
  wait_for(REQ_TX_BYTE, seen);
  value = tx_value_o;
  if (seen) begin
    tx_done_i = 1'b1;
    next_cycle();
    tx_done_i = 1'b0;
  end
endtask

// Bus monitor pulses
task automatic pulse_rstart();
  rstart_det_i = 1'b1;
  next_cycle();
  rstart_det_i = 1'b0;
endtask

task automatic pulse_stop();
  stop_det_i = 1'b1;
  next_cycle();
  stop_det_i = 1'b0;
endtask

// Done pulse, then Idle, then back in WaitCCC
task automatic finish_frame();
  logic seen;
  wait_for(DONE_PULSE, seen);
  next_cycle();
  check_bit(done_fsm_o, 1'b0, "done_fsm_o longer than one cycle");
  next_cycle();
endtask

task automatic check_byte(input bus_byte_t got, input bus_byte_t exp, input string what);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s, got 0x%02h, expected 0x%02h", $time, what, got, exp);
    err_cnt++;
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s, got %b, expected %b", $time, what, got, exp);
    err_cnt++;
  end
endtask

task automatic check_addr(input addr7_t got, input addr7_t exp, input string what);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s, got 7'h%02h, expected 7'h%02h", $time, what, got, exp);
    err_cnt++;
  end
endtask

`endif

//--- tb/tb_ccc_handler.sv
// Directed testbench for the CCC handler top level, run as the simulation top
`timescale 1ns/10ps
`default_nettype none

module tb_ccc_handler
  import i3c_bus_pkg::*;
  import i3c_ccc_pkg::*;
();

  localparam int     TIMEOUT_CYC  = 40;
  localparam addr7_t FOREIGN_ADDR = 7'h7A;

  logic                  clk_i;
  logic                  rst_ni;
  ccc_code_t             ccc_i;
  logic                  ccc_valid_i;
  logic                  done_fsm_o;
  logic                  start_det_i;
  logic                  rstart_det_i;
  logic                  stop_det_i;
  logic                  rx_done_i;
  bus_byte_t             rx_data_i;
  logic                  tx_done_i;
  logic                  rx_req_bit_o;
  logic                  rx_req_byte_o;
  logic                  tx_req_bit_o;
  logic                  tx_req_byte_o;
  bus_byte_t             tx_value_o;
  addr7_t                sta_addr_i;
  logic                  sta_addr_valid_i;
  addr7_t                dyn_addr_i;
  logic                  dyn_addr_valid_i;
  bus_byte_t             get_bcr_i;
  bus_byte_t             get_dcr_i;
  logic [2*BYTE_W-1:0]   get_status_i;
  logic [2*BYTE_W-1:0]   get_mwl_i;
  logic [2*BYTE_W-1:0]   get_mrl_i;
  logic [GET_RESP_W-1:0] get_pid_i;
  logic                  rstdaa_o;
  bus_byte_t             set_dasa_o;
  logic                  set_dasa_valid_o;

  int        err_cnt;
  int        timeout_cnt;
  int        rstdaa_cnt;
  int        dasa_cnt;
  bus_byte_t exp_q[$];

  `include "ccc_bus_model.svh"

  ccc_handler_top dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ccc_i            (ccc_i),
    .ccc_valid_i      (ccc_valid_i),
    .done_fsm_o       (done_fsm_o),
    .start_det_i      (start_det_i),
    .rstart_det_i     (rstart_det_i),
    .stop_det_i       (stop_det_i),
    .rx_done_i        (rx_done_i),
    .rx_data_i        (rx_data_i),
    .tx_done_i        (tx_done_i),
    .rx_req_bit_o     (rx_req_bit_o),
    .rx_req_byte_o    (rx_req_byte_o),
    .tx_req_bit_o     (tx_req_bit_o),
    .tx_req_byte_o    (tx_req_byte_o),
    .tx_value_o       (tx_value_o),
    .sta_addr_i       (sta_addr_i),
    .sta_addr_valid_i (sta_addr_valid_i),
    .dyn_addr_i       (dyn_addr_i),
    .dyn_addr_valid_i (dyn_addr_valid_i),
    .get_bcr_i        (get_bcr_i),
    .get_dcr_i        (get_dcr_i),
    .get_status_i     (get_status_i),
    .get_mwl_i        (get_mwl_i),
    .get_mrl_i        (get_mrl_i),
    .get_pid_i        (get_pid_i),
    .rstdaa_o         (rstdaa_o),
    .set_dasa_o       (set_dasa_o),
    .set_dasa_valid_o (set_dasa_valid_o)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  // Pulse counters, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rstdaa_o) rstdaa_cnt++;
    if (set_dasa_valid_o) dasa_cnt++;
  end

  // Primary FSM hands over a code for one cycle
  task automatic issue_ccc(input ccc_code_t code);
    ccc_i       = code;
    ccc_valid_i = 1'b1;
    next_cycle();
    ccc_valid_i = 1'b0;
    check_bit(rx_req_bit_o, 1'b1, "T-bit request one cycle after ccc_valid_i");
  endtask

  // Response bytes, most significant first
  task automatic expect_get(input ccc_code_t code);
    exp_q.delete();
    case (code)
      CCC_DIRECT_GETBCR: exp_q.push_back(get_bcr_i);
      CCC_DIRECT_GETDCR: exp_q.push_back(get_dcr_i);
      CCC_DIRECT_GETSTATUS: begin
        exp_q.push_back(get_status_i[15:8]);
        exp_q.push_back(get_status_i[7:0]);
      end
      CCC_DIRECT_GETMWL: begin
        exp_q.push_back(get_mwl_i[15:8]);
        exp_q.push_back(get_mwl_i[7:0]);
      end
      // Max IBI payload byte last
      CCC_DIRECT_GETMRL: begin
        exp_q.push_back(get_mrl_i[15:8]);
        exp_q.push_back(get_mrl_i[7:0]);
        exp_q.push_back(8'hFF);
      end
      CCC_DIRECT_GETPID: begin
        for (int k = 5; k >= 0; k--) exp_q.push_back(get_pid_i[8*k +: 8]);
      end
      default: ;
    endcase
  endtask

  // Code, T-bit, Sr, address byte and its ACK
  task automatic open_direct(input ccc_code_t code, input bus_byte_t addr_byte);
    logic ack;
    issue_ccc(code);
    send_bit(1'b0);
    pulse_rstart();
    send_byte(addr_byte);
    take_tx_bit(ack);
    check_bit(ack, 1'b0, "address ACK value");
  endtask

  // Reserved address after Sr closes the frame
  task automatic close_direct();
    logic ack;
    send_byte(RSVD_ADDR);
    take_tx_bit(ack);
    check_bit(ack, 1'b0, "reserved address ACK value");
    finish_frame();
  endtask

  task automatic run_get(input ccc_code_t code, input addr7_t target);
    bus_byte_t got;
    logic      tbit;
    expect_get(code);
    open_direct(code, {target, 1'b1});
    foreach (exp_q[i]) begin
      take_tx_byte(got);
      check_byte(got, exp_q[i], $sformatf("GET 0x%02h byte %0d", code, i));
      take_tx_bit(tbit);
      check_bit(tbit, i != exp_q.size() - 1, $sformatf("GET 0x%02h T-bit %0d", code, i));
    end
    close_direct();
  endtask

  task automatic run_setdasa(input addr7_t target, input addr7_t new_da, input logic hit);
    int base;
    base = dasa_cnt;
    open_direct(CCC_DIRECT_SETDASA, {target, 1'b0});
    if (hit) begin
      send_byte({new_da, 1'b0});
      // Data T-bit completes, capture follows one cycle later
      send_bit(1'b0);
      check_bit(set_dasa_valid_o, 1'b1, "set_dasa_valid_o after data T-bit");
      check_addr(set_dasa_o[7:1], new_da, "SETDASA address");
      next_cycle();
      check_bit(set_dasa_valid_o, 1'b0, "set_dasa_valid_o width");
      pulse_stop();
      finish_frame();
    end else begin
      check_bit(rx_req_byte_o, 1'b1, "foreign address back to address phase");
      close_direct();
    end
    check_bit((dasa_cnt - base) == int'(hit), 1'b1, "set_dasa_valid_o pulse count");
  endtask

  task automatic run_broadcast(input ccc_code_t code);
    int   rst_base;
    int   dasa_base;
    logic is_rst;
    rst_base  = rstdaa_cnt;
    dasa_base = dasa_cnt;
    is_rst    = code == CCC_BCAST_RSTDAA;
    issue_ccc(code);
    send_bit(1'b0);
    // Broadcast action cycle
    check_bit(done_fsm_o, 1'b0, "done_fsm_o one cycle after broadcast T-bit");
    next_cycle();
    check_bit(done_fsm_o, 1'b1, "done_fsm_o two cycles after broadcast T-bit");
    check_bit(rstdaa_o, is_rst, "rstdaa_o with done");
    check_bit(set_dasa_valid_o, !is_rst, "set_dasa_valid_o with done");
    if (!is_rst) check_addr(set_dasa_o[7:1], sta_addr_i, "SETAASA static address");
    finish_frame();
    check_bit((rstdaa_cnt - rst_base) == int'(is_rst), 1'b1, "rstdaa_o pulse count");
    check_bit((dasa_cnt - dasa_base) == int'(!is_rst), 1'b1, "SETAASA pulse count");
  endtask

  // Dynamic address first, static one only as fallback
  task automatic run_matching();
    open_direct(CCC_DIRECT_GETBCR, {sta_addr_i, 1'b1});
    check_bit(tx_req_byte_o, 1'b0, "static address ignored while dynamic is valid");
    close_direct();
    dyn_addr_valid_i = 1'b0;
    run_get(CCC_DIRECT_GETDCR, sta_addr_i);
    dyn_addr_valid_i = 1'b1;
    run_get(CCC_DIRECT_GETBCR, dyn_addr_i);
  endtask

  task automatic run_stop_abort();
    bus_byte_t got;
    open_direct(CCC_DIRECT_GETPID, {dyn_addr_i, 1'b1});
    take_tx_byte(got);
    check_byte(got, get_pid_i[47:40], "first GETPID byte before stop");
    pulse_stop();
    check_bit(done_fsm_o, 1'b1, "done_fsm_o on the cycle after stop");
    finish_frame();
    run_get(CCC_DIRECT_GETSTATUS, dyn_addr_i);
  endtask

  initial begin
    ccc_code_t get_codes[6];
    get_codes = '{CCC_DIRECT_GETBCR, CCC_DIRECT_GETDCR, CCC_DIRECT_GETSTATUS,
                  CCC_DIRECT_GETMWL, CCC_DIRECT_GETMRL, CCC_DIRECT_GETPID};
    err_cnt     = 0;
    timeout_cnt = 0;
    rstdaa_cnt  = 0;
    dasa_cnt    = 0;
    void'($urandom(32'h51e2));
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    ccc_i            = '0;
    ccc_valid_i      = 1'b0;
    start_det_i      = 1'b0;
    rstart_det_i     = 1'b0;
    stop_det_i       = 1'b0;
    rx_done_i        = 1'b0;
    rx_data_i        = '0;
    tx_done_i        = 1'b0;
    // Addresses kept clear of 7'h7E and of FOREIGN_ADDR
    dyn_addr_i       = addr7_t'(8 + $urandom % 112);
    sta_addr_i       = addr7_t'(8 + $urandom % 112);
    if (sta_addr_i == dyn_addr_i) sta_addr_i = dyn_addr_i ^ 7'h01;
    sta_addr_valid_i = 1'b1;
    dyn_addr_valid_i = 1'b1;
    get_bcr_i        = bus_byte_t'($urandom);
    get_dcr_i        = bus_byte_t'($urandom);
    get_status_i     = 16'($urandom);
    get_mwl_i        = 16'($urandom);
    get_mrl_i        = 16'($urandom);
    get_pid_i[47:32] = 16'($urandom);
    get_pid_i[31:0]  = $urandom;

    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_bit(rx_req_bit_o | rx_req_byte_o | tx_req_bit_o | tx_req_byte_o, 1'b0,
              "requests after reset");
    check_bit(done_fsm_o | rstdaa_o | set_dasa_valid_o, 1'b0, "pulses after reset");
    next_cycle();
    next_cycle();

    foreach (get_codes[i]) run_get(get_codes[i], dyn_addr_i);
    run_setdasa(dyn_addr_i, addr7_t'($urandom), 1'b1);
    run_setdasa(FOREIGN_ADDR, addr7_t'($urandom), 1'b0);
    run_broadcast(CCC_BCAST_RSTDAA);
    run_broadcast(CCC_BCAST_SETAASA);
    run_matching();
    run_stop_abort();

    $display("Value errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_ccc_handler

`default_nettype wire

//--- vlog.f
+incdir+tb
design/i3c_bus_pkg.sv
design/i3c_ccc_pkg.sv
design/ccc_sequencer.sv
design/get_response_mux.sv
design/set_action_unit.sv
design/ccc_handler_top.sv
tb/tb_ccc_handler.sv
